//--- Makefile
SIM  := obj_dir/Vtb_cpu_control
SRCS := $(wildcard design/*.sv test/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_cpu_control -f compile.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- compile.f
design/isa_pkg.sv
design/ctrl_pkg.sv
design/stage_sequencer.sv
design/microcode_decoder.sv
design/cpu_control_top.sv
test/tb_cpu_control.sv

//--- design/cpu_control_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control unit top, every strobe is a level valid for one cycle
// opcode must be held for the full instruction; reset is synchronous
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_control_top #(
    parameter int stage_w = 4
) (
    input  logic               clk,
    input  logic               ireg_reset,
    input  isa_pkg::opcode_t   opcode,
    input  logic               alu_zero,
    output logic               areg_load,
    output logic               areg_out,
    output logic               breg_load,
    output logic               breg_out,
    output logic               hreg_load,
    output logic               hreg_out,
    output logic               lreg_load,
    output logic               lreg_out,
    output logic               mreg_h_load,
    output logic               mreg_l_load,
    output logic               ireg_load,
    output logic               instr_done,
    output logic               ram_write,
    output logic               ram_read_pc,
    output logic               ram_read_mreg,
    output logic               alu_out,
    output isa_pkg::alu_mode_t alu_mode,
    output logic               cnt_en,
    output logic               cnt_wr,
    output logic               halt,
    output logic [stage_w-1:0] stage_no       // Current micro-step
);

    logic [stage_w-1:0]   stage;
    ctrl_pkg::ctrl_word_t ctrl;

    stage_sequencer #(.stage_w(stage_w)) i_sequencer (
        .clk        (clk),
        .ireg_reset (ireg_reset),
        .instr_done (ctrl.instr_done),
        .halt       (ctrl.halt),
        .stage      (stage)
    );

    microcode_decoder #(.stage_w(stage_w)) i_decoder (
        .clk        (clk),
        .ireg_reset (ireg_reset),
        .opcode     (opcode),
        .alu_zero   (alu_zero),
        .stage      (stage),
        .ctrl       (ctrl)
    );

    assign areg_load     = ctrl.areg_load;
    assign areg_out      = ctrl.areg_out;
    assign breg_load     = ctrl.breg_load;
    assign breg_out      = ctrl.breg_out;
    assign hreg_load     = ctrl.hreg_load;
    assign hreg_out      = ctrl.hreg_out;
    assign lreg_load     = ctrl.lreg_load;
    assign lreg_out      = ctrl.lreg_out;
    assign mreg_h_load   = ctrl.mreg_h_load;
    assign mreg_l_load   = ctrl.mreg_l_load;
    assign ireg_load     = ctrl.ireg_load;
    assign instr_done    = ctrl.instr_done;
    assign ram_write     = ctrl.ram_write;
    assign ram_read_pc   = ctrl.ram_read_pc;
    assign ram_read_mreg = ctrl.ram_read_mreg;
    assign alu_out       = ctrl.alu_out;
    assign alu_mode      = ctrl.alu_mode;
    assign cnt_en        = ctrl.cnt_en;
    assign cnt_wr        = ctrl.cnt_wr;
    assign halt          = ctrl.halt;
    assign stage_no      = stage;

endmodule

//--- design/ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath control word, one strobe per resource, MSB first as listed
// All strobes are active high and valid for a single clock cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ctrl_pkg;

    localparam int max_stages = 5;          // Longest instruction plus one

    typedef struct packed {
        logic               areg_load;
        logic               areg_out;       // Bus source
        logic               breg_load;
        logic               breg_out;       // Bus source
        logic               hreg_load;
        logic               hreg_out;       // Bus source
        logic               lreg_load;
        logic               lreg_out;       // Bus source
        logic               mreg_h_load;
        logic               mreg_l_load;
        logic               ireg_load;
        logic               instr_done;     // Last cycle of an instruction
        logic               ram_write;
        logic               ram_read_pc;    // Bus source, PC addressed
        logic               ram_read_mreg;  // Bus source, MREG addressed
        logic               alu_out;        // Bus source
        isa_pkg::alu_mode_t alu_mode;
        logic               cnt_en;         // PC increment
        logic               cnt_wr;         // PC load from MREG
        logic               halt;
    } ctrl_word_t;

    localparam ctrl_word_t ctrl_idle = '{alu_mode: isa_pkg::ALU_NONE, default: 1'b0};

endpackage

//--- design/isa_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcode and ALU mode encodings of the 8-bit bus CPU
// Byte values missing from opcode_t are undefined and decode to idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

    localparam int opcode_w = 8;            // One instruction byte

    typedef enum logic [opcode_w-1:0] {
        OP_NOP     = 8'h00,
        OP_LDAI    = 8'h01,
        OP_LDBI    = 8'h02,
        OP_LDHI    = 8'h03,
        OP_LDLI    = 8'h04,
        OP_LDA_HL  = 8'h05,                 // A <- mem[HL]
        OP_STA_HL  = 8'h06,                 // mem[HL] <- A
        OP_LDA_RAM = 8'h07,                 // Two address bytes follow
        OP_STA_RAM = 8'h08,
        OP_ADD     = 8'h10,
        OP_SUB     = 8'h11,
        OP_AND     = 8'h12,
        OP_OR      = 8'h13,
        OP_XOR     = 8'h14,
        OP_NOT     = 8'h15,
        OP_JMP     = 8'h20,
        OP_JZ      = 8'h21,                 // Taken on ALU zero flag
        OP_MOV_AB  = 8'h30,
        OP_MOV_BA  = 8'h31,
        OP_HALT    = 8'hFF
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_NOT  = 3'd6                     // Unary, operates on A
    } alu_mode_t;

    // ALU function for an arithmetic or logic opcode
    function automatic alu_mode_t alu_mode_of(input opcode_t op);
        case (op)
            OP_ADD:  return ALU_ADD;
            OP_SUB:  return ALU_SUB;
            OP_AND:  return ALU_AND;
            OP_OR:   return ALU_OR;
            OP_XOR:  return ALU_XOR;
            OP_NOT:  return ALU_NOT;
            default: return ALU_NONE;
        endcase
    endfunction

endpackage

//--- design/microcode_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational microcode table, opcode and stage in, control word out
// The opcode must stay stable for the whole instruction; stage_w >= 3
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module microcode_decoder #(
    parameter int stage_w = 4
) (
    input  logic                 clk,
    input  logic                 ireg_reset,
    input  isa_pkg::opcode_t     opcode,
    input  logic                 alu_zero,
    input  logic [stage_w-1:0]   stage,
    output ctrl_pkg::ctrl_word_t ctrl
);

    localparam logic [stage_w-1:0] st0      = stage_w'(0);
    localparam logic [stage_w-1:0] st1      = stage_w'(1);
    localparam logic [stage_w-1:0] st2      = stage_w'(2);
    localparam logic [stage_w-1:0] st3      = stage_w'(3);
    localparam logic [stage_w-1:0] st_limit = stage_w'(ctrl_pkg::max_stages);

    // Opcode fetch that closes every instruction
    localparam ctrl_pkg::ctrl_word_t fetch_word = '{
        ireg_load:   1'b1,
        instr_done:  1'b1,
        ram_read_pc: 1'b1,
        cnt_en:      1'b1,
        alu_mode:    isa_pkg::ALU_NONE,
        default:     1'b0
    };

    logic opcode_known;
    logic via_hl;       // Address from H and L, not from inline bytes
    logic is_load;      // Memory read into A, not a store
    logic jump_taken;

    assign via_hl     = (opcode == isa_pkg::OP_LDA_HL) || (opcode == isa_pkg::OP_STA_HL);
    assign is_load    = (opcode == isa_pkg::OP_LDA_HL) || (opcode == isa_pkg::OP_LDA_RAM);
    assign jump_taken = (opcode == isa_pkg::OP_JMP) || alu_zero;

    always_comb begin
        ctrl         = ctrl_pkg::ctrl_idle;
        opcode_known = 1'b1;

        case (opcode)
            isa_pkg::OP_NOP: begin
                if (stage == st0) begin
                    ctrl = fetch_word;
                end
            end
            isa_pkg::OP_HALT: begin
                if (stage == st0) begin
                    ctrl.halt = 1'b1;               // Held, stage freezes
                end
            end
            isa_pkg::OP_LDAI, isa_pkg::OP_LDBI, isa_pkg::OP_LDHI, isa_pkg::OP_LDLI: begin
                if (stage == st0) begin             // Operand byte into target
                    ctrl.areg_load   = (opcode == isa_pkg::OP_LDAI);
                    ctrl.breg_load   = (opcode == isa_pkg::OP_LDBI);
                    ctrl.hreg_load   = (opcode == isa_pkg::OP_LDHI);
                    ctrl.lreg_load   = (opcode == isa_pkg::OP_LDLI);
                    ctrl.ram_read_pc = 1'b1;
                    ctrl.cnt_en      = 1'b1;
                end else if (stage == st1) begin
                    ctrl = fetch_word;
                end
            end
            isa_pkg::OP_LDA_HL, isa_pkg::OP_STA_HL,
            isa_pkg::OP_LDA_RAM, isa_pkg::OP_STA_RAM: begin
                if (stage == st0) begin             // High address byte
                    ctrl.mreg_h_load = 1'b1;
                    ctrl.hreg_out    = via_hl;
                    ctrl.ram_read_pc = !via_hl;
                    ctrl.cnt_en      = !via_hl;
                end else if (stage == st1) begin    // Low address byte
                    ctrl.mreg_l_load = 1'b1;
                    ctrl.lreg_out    = via_hl;
                    ctrl.ram_read_pc = !via_hl;
                    ctrl.cnt_en      = !via_hl;
                end else if (stage == st2) begin    // Data transfer at MREG
                    ctrl.areg_load     = is_load;
                    ctrl.ram_read_mreg = is_load;
                    ctrl.areg_out      = !is_load;
                    ctrl.ram_write     = !is_load;
                end else if (stage == st3) begin
                    ctrl = fetch_word;
                end
            end
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
            isa_pkg::OP_OR, isa_pkg::OP_XOR, isa_pkg::OP_NOT: begin
                if (stage == st0) begin
                    ctrl.alu_mode = isa_pkg::alu_mode_of(opcode);
                end else if (stage == st1) begin    // Result back into A
                    ctrl.areg_load = 1'b1;
                    ctrl.alu_out   = 1'b1;
                end else if (stage == st2) begin
                    ctrl = fetch_word;
                end
            end
            isa_pkg::OP_JMP, isa_pkg::OP_JZ: begin
                if (jump_taken) begin
                    if (stage == st0) begin
                        ctrl.mreg_h_load = 1'b1;
                        ctrl.ram_read_pc = 1'b1;
                        ctrl.cnt_en      = 1'b1;
                    end else if (stage == st1) begin
                        ctrl.mreg_l_load = 1'b1;
                        ctrl.ram_read_pc = 1'b1;
                        ctrl.cnt_en      = 1'b1;
                    end else if (stage == st2) begin
                        ctrl.cnt_wr = 1'b1;         // PC <- MREG
                    end else if (stage == st3) begin
                        ctrl = fetch_word;
                    end
                end else begin
                    // Not taken, step the PC over both address bytes
                    if (stage == st0 || stage == st1) begin
                        ctrl.cnt_en = 1'b1;
                    end else if (stage == st2) begin
                        ctrl = fetch_word;
                    end
                end
            end
            isa_pkg::OP_MOV_AB, isa_pkg::OP_MOV_BA: begin
                if (stage == st0) begin
                    ctrl.areg_out  = (opcode == isa_pkg::OP_MOV_AB);
                    ctrl.breg_load = (opcode == isa_pkg::OP_MOV_AB);
                    ctrl.breg_out  = (opcode == isa_pkg::OP_MOV_BA);
                    ctrl.areg_load = (opcode == isa_pkg::OP_MOV_BA);
                end else if (stage == st1) begin
                    ctrl = fetch_word;
                end
            end
            default: begin
                opcode_known = 1'b0;                // Idle word, stage runs on
            end
        endcase

        if (ireg_reset) begin
            ctrl = ctrl_pkg::ctrl_idle;
        end
    end

    // Only one driver on the shared data bus per cycle
    property p_single_bus_source;
        @(posedge clk) disable iff (ireg_reset)
        $onehot0({ctrl.areg_out, ctrl.breg_out, ctrl.hreg_out, ctrl.lreg_out,
                  ctrl.alu_out, ctrl.ram_read_pc, ctrl.ram_read_mreg});
    endproperty

    a_single_bus_source : assert property (p_single_bus_source)
        else $error("bus contention, more than one source enabled");

    // Reaching stage max_stages means the counter ran max_stages steps from 0,
    // which a known opcode held over that span cannot do since it ends sooner
    property p_stage_bound;
        @(posedge clk) disable iff (ireg_reset)
        (stage == st_limit) |->
            !($past(opcode_known, ctrl_pkg::max_stages) &&
              ($past(opcode, ctrl_pkg::max_stages) == $past(opcode)));
    endproperty

    a_stage_bound : assert property (p_stage_bound)
        else $error("known opcode ran past the last microcode stage");

endmodule

//--- design/stage_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Micro-step counter that wraps modulo 2**stage_w unless the instruction ends
// HALT freezes the count until the next reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stage_sequencer #(
    parameter int stage_w = 4
) (
    input  logic               clk,
    input  logic               ireg_reset,
    input  logic               instr_done,
    input  logic               halt,
    output logic [stage_w-1:0] stage
);

    // Priority is reset, then end of instruction, then halt
    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            stage <= '0;
        end else if (instr_done) begin
            stage <= '0;                    // Next opcode starts at stage 0
        end else if (!halt) begin
            stage <= stage + 1'b1;          // Wraps on undefined opcodes
        end
    end

    // The decoder must never end an instruction in a halted cycle
    // or the halt would be lost when the stage clears
    property p_done_halt_exclusive;
        @(posedge clk) disable iff (ireg_reset)
        !(instr_done && halt);
    endproperty

    a_done_halt_exclusive : assert property (p_done_halt_exclusive)
        else $error("instr_done and halt asserted together");

endmodule

//--- test/cpu_control_trace.txt
# reset opcode alu_zero expected_ctrl expected_stage, all hex, one clock cycle per line
# expected_ctrl is the 22-bit control word, areg_load in bit 21 down to halt in bit 0
0 00 0 000D04 0   NOP
0 01 0 200104 0   LDAI
0 01 0 000D04 1
0 04 0 008104 0   LDLI
0 04 0 000D04 1
0 30 0 180000 0   MOV_AB
0 30 0 000D04 1
0 31 0 240000 0   MOV_BA
0 31 0 000D04 1
0 05 0 012000 0   LDA_HL
0 05 0 005000 1
0 05 0 200080 2
0 05 0 000D04 3
0 08 0 002104 0   STA_RAM
0 08 0 001104 1
0 08 0 100200 2
0 08 0 000D04 3
0 10 0 000008 0   ADD
0 10 0 200040 1
0 10 0 000D04 2
0 15 0 000030 0   NOT
0 15 0 200040 1
0 15 0 000D04 2
0 20 0 002104 0   JMP
0 20 0 001104 1
0 20 0 000002 2
0 20 0 000D04 3
0 21 1 002104 0   JZ taken
0 21 1 001104 1
0 21 1 000002 2
0 21 1 000D04 3
0 21 0 000004 0   JZ not taken
0 21 0 000004 1
0 21 0 000D04 2
0 FF 0 000001 0   HALT holds stage
0 FF 0 000001 0
0 FF 0 000001 0
1 FF 0 000000 0   reset releases halt
0 42 0 000000 0   undefined opcode
0 42 0 000000 1
0 42 0 000000 2
1 42 0 000000 3
0 00 0 000D04 0   NOP after reset

//--- test/tb_cpu_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Trace-driven testbench, one trace record per clock cycle after reset
// Run from the project root so the trace path resolves
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_cpu_control;

    localparam int stage_w       = 4;
    localparam int clk_period    = 40;
    localparam int reset_cycles  = 16;
    localparam int margin_cycles = 20;

    logic               clk;
    logic               ireg_reset;
    isa_pkg::opcode_t   opcode;
    logic               alu_zero;
    wire  [21:0]        ctrl_word;          // Ports packed MSB first
    wire  [stage_w-1:0] stage_no;
    logic               trace_loaded = 1'b0;
    time                watchdog_limit;

    logic               rst_q[$];
    logic [7:0]         opcode_q[$];
    logic               zero_q[$];
    logic [21:0]        exp_ctrl_q[$];
    logic [stage_w-1:0] exp_stage_q[$];

    cpu_control_top #(.stage_w(stage_w)) i_dut (
        .clk           (clk),
        .ireg_reset    (ireg_reset),
        .opcode        (opcode),
        .alu_zero      (alu_zero),
        .areg_load     (ctrl_word[21]),
        .areg_out      (ctrl_word[20]),
        .breg_load     (ctrl_word[19]),
        .breg_out      (ctrl_word[18]),
        .hreg_load     (ctrl_word[17]),
        .hreg_out      (ctrl_word[16]),
        .lreg_load     (ctrl_word[15]),
        .lreg_out      (ctrl_word[14]),
        .mreg_h_load   (ctrl_word[13]),
        .mreg_l_load   (ctrl_word[12]),
        .ireg_load     (ctrl_word[11]),
        .instr_done    (ctrl_word[10]),
        .ram_write     (ctrl_word[9]),
        .ram_read_pc   (ctrl_word[8]),
        .ram_read_mreg (ctrl_word[7]),
        .alu_out       (ctrl_word[6]),
        .alu_mode      (ctrl_word[5:3]),
        .cnt_en        (ctrl_word[2]),
        .cnt_wr        (ctrl_word[1]),
        .halt          (ctrl_word[0]),
        .stage_no      (stage_no)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] r, o, z, c, s;
        fd = $fopen("test/cpu_control_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open trace file test/cpu_control_trace.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;                   // Column notes and blank lines
            end
            n = $sscanf(line, "%h %h %h %h %h", r, o, z, c, s);
            if (n != 5) begin
                abort_run($sformatf("malformed trace line: %s", line));
            end
            rst_q.push_back(r[0]);
            opcode_q.push_back(o[7:0]);
            zero_q.push_back(z[0]);
            exp_ctrl_q.push_back(c[21:0]);
            exp_stage_q.push_back(s[stage_w-1:0]);
        end
        $fclose(fd);
    endtask

    task automatic check_outputs(input logic [21:0] exp_ctrl,
                                 input logic [stage_w-1:0] exp_stage,
                                 input string where);
        assert (ctrl_word === exp_ctrl)
            else abort_run($sformatf("FAIL ctrl_word at %s: got 0x%06h expected 0x%06h",
                                     where, ctrl_word, exp_ctrl));
        assert (stage_no === exp_stage)
            else abort_run($sformatf("FAIL stage_no at %s: got 0x%0h expected 0x%0h",
                                     where, stage_no, exp_stage));
    endtask

    // Trace length sets the time budget
    initial begin
        wait (trace_loaded);
        #(watchdog_limit);
        abort_run("watchdog timeout: trace did not finish");
    end

    initial begin
        ireg_reset = 1'b1;
        opcode     = isa_pkg::OP_NOP;
        alu_zero   = 1'b0;
        load_trace();
        watchdog_limit = (rst_q.size() + reset_cycles + margin_cycles) * clk_period;
        trace_loaded   = 1'b1;

        for (int c = 0; c < reset_cycles; c++) begin
            @(posedge clk);
            ireg_reset <= 1'b1;
            @(negedge clk);
            check_outputs(22'h0, '0, $sformatf("reset cycle %0d", c));  // Idle word
        end

        for (int i = 0; i < rst_q.size(); i++) begin
            @(posedge clk);
            ireg_reset <= rst_q[i];
            opcode     <= isa_pkg::opcode_t'(opcode_q[i]);
            alu_zero   <= zero_q[i];
            @(negedge clk);                 // Decoder output settled
            check_outputs(exp_ctrl_q[i], exp_stage_q[i], $sformatf("trace record %0d", i));
        end

        $display("All tests passed");
        $finish;
    end

endmodule
